// File: Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module ccpd_top_tb -o Vccpd_top_tb

run: compile
	./obj_dir/Vccpd_top_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: bench/ccpd_testdata.txt
// gate_dly gate_wid inj_dly inj_wid rec_len src thresh ch_en base0 base1 base2 base3 bp count
// all hex; src 0 gate 1 threshold; bp 0 ready high, 1 random, 2 held low during the record
03 08 02 03 04 0 0000 f 0000 0100 0200 3ffe 0 10
01 06 01 02 0c 0 0000 5 0010 0020 0030 0040 0 18
02 05 00 01 08 1 0040 f 0010 1000 2000 3000 0 20
04 06 02 01 0c 0 0000 b 0100 0200 0300 0400 1 24
01 04 00 01 10 0 0000 f 3ff0 0005 0aaa 1555 1 40
02 04 01 01 18 0 0000 f 0000 0111 0222 0333 2 41

// File: bench/ccpd_top_checker.sv
////////////////////
// Assertions bound into ccpd_top
// Checked only while out of reset
////////////////////

`timescale 1ns/1ps

module ccpd_top_checker (
    input logic                             ADC_ENC,
    input logic                             i_rst_n,
    input logic                             i_out_valid,
    input logic                             i_out_ready,
    input sampler_pkg::out_word_t           i_out_data,
    input logic                             i_gate,
    input logic                             i_injection,
    input logic [sampler_pkg::N_CH-1:0]     i_read
);

    // Stalled word stays valid and unchanged
    data_held: assert property (@(posedge ADC_ENC) disable iff (!i_rst_n)
        (i_out_valid && !i_out_ready) |=> (i_out_valid && $stable(i_out_data)))
        else $error("output word changed or dropped while stalled");

    inj_in_gate: assert property (@(posedge ADC_ENC) disable iff (!i_rst_n)
        $rose(i_injection) |-> i_gate)     // Injection only inside the gate
        else $error("injection rose while the gate was low");

    one_read: assert property (@(posedge ADC_ENC) disable iff (!i_rst_n)
        $onehot0(i_read))
        else $error("more than one FIFO read strobe in a cycle");

endmodule

bind ccpd_top ccpd_top_checker ccpd_top_checker_i (
    .ADC_ENC     (ADC_ENC),
    .i_rst_n     (i_rst_n),
    .i_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .i_out_data  (o_out_data),
    .i_gate      (o_ccpd_gate),
    .i_injection (o_ccpd_injection),
    .i_read      (ch_read)
);

// File: bench/ccpd_top_tb.sv
////////////////////
// Testbench for ccpd_top
// Stimulus and expected counts come from bench/ccpd_testdata.txt
// Run from the project root so the data file path resolves
// Each test starts from a fresh reset
////////////////////

`timescale 1ns/1ps

module ccpd_top_tb;
    import sampler_pkg::*;

    localparam int N_TESTS  = 6;
    localparam int N_FIELDS = 14;
    localparam int HALF_NS  = 50;   // 100 ns period
    localparam int START_AT = 2;    // Edge after which the first gate start is driven
    localparam int TAIL     = 20;   // Idle cycles that catch extra words

    logic                   ADC_ENC;
    logic                   rst_n;
    logic                   gate_start;
    cnt_t                   gate_delay;
    cnt_t                   gate_width;
    cnt_t                   inj_delay;
    cnt_t                   inj_width;
    cnt_t                   rec_len;
    trig_src_t              trig_src;
    sample_t                threshold;
    sample_t [N_CH-1:0]     adc_sample;
    logic [N_CH-1:0]        ch_en;
    logic                   out_ready;
    logic                   ccpd_gate;
    logic                   ccpd_injection;
    logic                   out_valid;
    out_word_t              out_data;
    logic [N_CH-1:0]        lost;

    logic [15:0]            tdata [N_TESTS*N_FIELDS];
    logic [15:0]            base [N_CH];
    integer                 seed;
    int                     budget_cycles;
    int                     edge_no;        // Rising edges since reset release
    int                     bp_mode;        // 0 ready high, 1 random, 2 held low
    int                     exp_count;
    int                     gate_on;
    int                     gate_last;
    int                     inj_on;
    int                     inj_last;
    int                     t0;             // Edge after which the first recorded sample is driven
    int                     end_edge;
    int                     got_total;
    int                     got_ch [N_CH];
    out_word_t              exp_q [N_CH][$];

    ccpd_top ccpd_top_i (
        .ADC_ENC          (ADC_ENC),
        .i_rst_n          (rst_n),
        .i_gate_start     (gate_start),
        .i_gate_delay     (gate_delay),
        .i_gate_width     (gate_width),
        .i_inj_delay      (inj_delay),
        .i_inj_width      (inj_width),
        .i_rec_len        (rec_len),
        .i_trig_src       (trig_src),
        .i_threshold      (threshold),
        .i_adc_sample     (adc_sample),
        .i_ch_en          (ch_en),
        .i_out_ready      (out_ready),
        .o_ccpd_gate      (ccpd_gate),
        .o_ccpd_injection (ccpd_injection),
        .o_out_valid      (out_valid),
        .o_out_data       (out_data),
        .o_lost           (lost)
    );

    initial ADC_ENC = 1'b0;
    always #HALF_NS ADC_ENC = ~ADC_ENC;

    ////////////////////
    // Reporting
    task automatic abort_run(string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_word(out_word_t got, out_word_t exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH time %0t o_out_data got %h expected %h",
                                $time, got, exp));
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH time %0t %s got %b expected %b",
                                $time, name, got, exp));
    endtask

    task automatic check_lost(logic [N_CH-1:0] got, logic [N_CH-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH time %0t o_lost got %b expected %b",
                                $time, got, exp));
    endtask

    ////////////////////
    // Test setup
    task automatic load_test(int n);
        int f;
        f          = n * N_FIELDS;
        gate_delay = cnt_t'(tdata[f]);
        gate_width = cnt_t'(tdata[f+1]);
        inj_delay  = cnt_t'(tdata[f+2]);
        inj_width  = cnt_t'(tdata[f+3]);
        rec_len    = cnt_t'(tdata[f+4]);
        trig_src   = trig_src_t'(tdata[f+5][0]);
        threshold  = sample_t'(tdata[f+6]);
        ch_en      = tdata[f+7][N_CH-1:0];
        for (int ch = 0; ch < N_CH; ch++)
            base[ch] = tdata[f+8+ch];
        bp_mode    = int'(tdata[f+12]);
        exp_count  = int'(tdata[f+13]);
    endtask

    task automatic build_expected();
        out_word_t w;
        gate_on   = START_AT + int'(gate_delay) + 2;  // Start seen one edge late, then D+1
        gate_last = gate_on + int'(gate_width) - 1;
        inj_on    = gate_on + int'(inj_delay) + 2;    // Gate edge seen one edge late
        inj_last  = inj_on + int'(inj_width) - 1;
        if (trig_src == TRIG_GATE)
            t0 = gate_on + 2;
        else
            t0 = int'(threshold) - int'(base[0]) + 3; // First ramp value above threshold
        end_edge = t0 + int'(rec_len) + 1;
        if (gate_last + 1 > end_edge)
            end_edge = gate_last + 1;
        if (inj_last + 1 > end_edge)
            end_edge = inj_last + 1;
        got_total = 0;
        for (int ch = 0; ch < N_CH; ch++)
        begin
            exp_q[ch].delete();
            got_ch[ch] = 0;
            if (ch_en[ch])
            begin
                for (int j = 0; j < int'(rec_len); j++)
                begin
                    w        = '0;
                    w.first  = (j == 0);
                    w.ch_id  = CH_ID_W'(ch);
                    w.sample = sample_t'((int'(base[ch]) + t0 + j) % (1 << SAMPLE_W));
                    exp_q[ch].push_back(w);
                end
            end
        end
    endtask

    task automatic reset_dut();
        rst_n      = 1'b0;
        edge_no    = 0;
        gate_start = 1'b0;
        out_ready  = 1'b0;
        for (int ch = 0; ch < N_CH; ch++)
            adc_sample[ch] = sample_t'(base[ch]);
        repeat (8) @(posedge ADC_ENC);
        #1;
        rst_n = 1'b1;
    endtask

    ////////////////////
    // Per-cycle drive and checks
    task automatic drive_inputs();
        logic [31:0] rnd;
        for (int ch = 0; ch < N_CH; ch++)
            adc_sample[ch] = sample_t'(base[ch] + 16'(edge_no));    // Ramp
        gate_start = (edge_no == START_AT) || (edge_no == gate_on);  // Second start inside gate
        case (bp_mode)
            0: out_ready = 1'b1;
            1:
            begin
                rnd       = $random(seed);
                out_ready = rnd[0];
            end
            default: out_ready = (edge_no >= t0 + int'(rec_len) + 2);
        endcase
    endtask

    task automatic step();
        out_word_t w;
        int        ch;
        @(posedge ADC_ENC);
        #1;
        edge_no++;
        drive_inputs();
        check_bit("o_ccpd_gate", ccpd_gate, (edge_no >= gate_on) && (edge_no <= gate_last));
        check_bit("o_ccpd_injection", ccpd_injection,
                  (edge_no >= inj_on) && (edge_no <= inj_last));
        if (out_valid && out_ready)     // Taken at the next edge
        begin
            w  = out_data;
            ch = int'(w.ch_id);
            if (!ch_en[ch] || exp_q[ch].size() == 0)
                abort_run($sformatf("word %h from channel %0d was not expected at %0t",
                                    w, ch, $time));
            check_word(w, exp_q[ch].pop_front());
            got_ch[ch]++;
            got_total++;
        end
    endtask

    task automatic run_test(int n);
        logic [N_CH-1:0] exp_lost;
        load_test(n);
        build_expected();
        reset_dut();
        check_bit("o_ccpd_gate", ccpd_gate, 1'b0);
        check_bit("o_ccpd_injection", ccpd_injection, 1'b0);
        check_bit("o_out_valid", out_valid, 1'b0);
        check_lost(lost, '0);
        while (edge_no < end_edge || got_total < exp_count)
            step();
        repeat (TAIL) step();
        // Nothing drains while the output is held, so every FIFO overflows
        exp_lost = (int'(rec_len) > FIFO_DEPTH + 1) ? '1 : '0;
        check_lost(lost, exp_lost);
        for (int ch = 0; ch < N_CH; ch++)
        begin
            if (ch_en[ch] && exp_lost[ch])
            begin
                if (got_ch[ch] < FIFO_DEPTH || got_ch[ch] > FIFO_DEPTH + 1)
                    abort_run($sformatf("test %0d channel %0d delivered %0d words after overflow",
                                        n, ch, got_ch[ch]));
            end
            else if (ch_en[ch] && got_ch[ch] != int'(rec_len))
                abort_run($sformatf("test %0d channel %0d delivered %0d words instead of %0d",
                                    n, ch, got_ch[ch], rec_len));
        end
        if (got_total != exp_count)
            abort_run($sformatf("test %0d delivered %0d words, data file expects %0d",
                                n, got_total, exp_count));
    endtask

    ////////////////////
    // Main sequence
    initial
    begin
        rst_n         = 1'b0;
        gate_start    = 1'b0;
        gate_delay    = '0;
        gate_width    = '0;
        inj_delay     = '0;
        inj_width     = '0;
        rec_len       = '0;
        trig_src      = TRIG_GATE;
        threshold     = '0;
        adc_sample    = '0;
        ch_en         = '0;
        out_ready     = 1'b0;
        seed          = 32'h5f14;
        budget_cycles = 0;
        $readmemh("bench/ccpd_testdata.txt", tdata);
        for (int n = 0; n < N_TESTS; n++)
        begin
            budget_cycles += int'(tdata[n*N_FIELDS]) + int'(tdata[n*N_FIELDS+1])
                           + int'(tdata[n*N_FIELDS+2]) + int'(tdata[n*N_FIELDS+3])
                           + int'(tdata[n*N_FIELDS+4]) * N_CH * 4 + 50;
        end
        for (int n = 0; n < N_TESTS; n++)
            run_test(n);
        $display("PASS: all tests");
        $finish;
    end

    initial
    begin : watchdog
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge ADC_ENC);
        abort_run("timeout, the tests did not finish within the cycle budget");
    end

endmodule

// File: src/adc_channel_rx.sv
////////////////////
// One ADC channel, records i_rec_len samples per trigger
// i_rec_len at least 1 and stable during a record
// First-word-fall-through FIFO, o_lost is sticky until reset
////////////////////

`timescale 1ns/1ps

module adc_channel_rx #(
    parameter int CH_ID = 0
) (
    input  logic                   ADC_ENC,
    input  logic                   i_rst_n,
    input  logic                   i_trig,
    input  sampler_pkg::sample_t   i_sample,
    input  sampler_pkg::cnt_t      i_rec_len,
    input  logic                   i_read,
    output logic                   o_empty,
    output sampler_pkg::out_word_t o_data,
    output logic                   o_lost
);
    import sampler_pkg::*;

    rx_state_t             state;
    cnt_t                  rec_cnt;
    out_word_t             mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] fill;
    out_word_t             wr_word;
    logic                  full;
    logic                  wr_req;
    logic                  do_wr;
    logic                  do_rd;

    assign full    = (fill == FIFO_CNT_W'(FIFO_DEPTH));
    assign o_empty = (fill == '0);
    assign o_data  = mem[rd_ptr];
    assign wr_req  = (state == RECORD);
    assign do_wr   = wr_req & ~full;
    assign do_rd   = i_read & ~o_empty;

    always_comb
    begin
        wr_word        = '0;
        wr_word.first  = (rec_cnt == '0);
        wr_word.ch_id  = CH_ID_W'(CH_ID);
        wr_word.sample = i_sample;
    end

    ////////////////////
    // Record FSM
    always_ff @(posedge ADC_ENC)
    begin
        if (!i_rst_n)
        begin
            state   <= WAIT_TRIG;
            rec_cnt <= '0;
        end
        else if (state == WAIT_TRIG)
        begin
            rec_cnt <= '0;
            if (i_trig)
                state <= RECORD;
        end
        else if (rec_cnt == i_rec_len - cnt_t'(1))
        begin
            state <= WAIT_TRIG;     // Last sample written this cycle
        end
        else
        begin
            rec_cnt <= rec_cnt + 1'b1;
        end
    end

    ////////////////////
    // FIFO
    always_ff @(posedge ADC_ENC)
    begin
        if (do_wr)
            mem[wr_ptr] <= wr_word;
    end

    always_ff @(posedge ADC_ENC)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
            o_lost <= 1'b0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;    // Wraps, depth is a power of two
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            if (wr_req && full)
                o_lost <= 1'b1;     // Word dropped
        end
    end

endmodule

// File: src/adc_trigger.sv
////////////////////
// ADC trigger from gate edge or channel 0 threshold crossing
// o_trig is one cycle wide, one cycle after the event
////////////////////

`timescale 1ns/1ps

module adc_trigger (
    input  logic                   ADC_ENC,
    input  logic                   i_rst_n,
    input  sampler_pkg::trig_src_t i_src,
    input  logic                   i_gate,
    input  sampler_pkg::sample_t   i_sample,
    input  sampler_pkg::sample_t   i_threshold,
    output logic                   o_trig
);
    import sampler_pkg::*;

    logic gate_q;
    logic above;
    logic above_q;
    logic gate_evt;
    logic thresh_evt;

    assign above      = (i_sample > i_threshold);
    assign gate_evt   = i_gate & ~gate_q;       // Gate rising edge
    assign thresh_evt = above & ~above_q;       // First sample over threshold

    // Previous above-threshold result follows the sample in every cycle
    always_ff @(posedge ADC_ENC)
    begin
        above_q <= above;
    end

    always_ff @(posedge ADC_ENC)
    begin
        if (!i_rst_n)
        begin
            gate_q <= 1'b0;
            o_trig <= 1'b0;
        end
        else
        begin
            gate_q <= i_gate;
            o_trig <= (i_src == TRIG_GATE) ? gate_evt : thresh_evt;
        end
    end

endmodule

// File: src/ccpd_top.sv
////////////////////
// CCPD board logic in the ADC encode clock domain
// Gate and injection pulses, ADC trigger, four receive
// channels and the merged 32-bit output stream
// Configuration inputs are expected static while running
////////////////////

`timescale 1ns/1ps

module ccpd_top (
    input  logic                                       ADC_ENC,
    input  logic                                       i_rst_n,
    input  logic                                       i_gate_start,
    input  sampler_pkg::cnt_t                          i_gate_delay,
    input  sampler_pkg::cnt_t                          i_gate_width,
    input  sampler_pkg::cnt_t                          i_inj_delay,
    input  sampler_pkg::cnt_t                          i_inj_width,
    input  sampler_pkg::cnt_t                          i_rec_len,
    input  sampler_pkg::trig_src_t                     i_trig_src,
    input  sampler_pkg::sample_t                       i_threshold,
    input  sampler_pkg::sample_t [sampler_pkg::N_CH-1:0] i_adc_sample,
    input  logic [sampler_pkg::N_CH-1:0]               i_ch_en,
    input  logic                                       i_out_ready,
    output logic                                       o_ccpd_gate,
    output logic                                       o_ccpd_injection,
    output logic                                       o_out_valid,
    output sampler_pkg::out_word_t                     o_out_data,
    output logic [sampler_pkg::N_CH-1:0]               o_lost
);
    import sampler_pkg::*;

    logic                   gate_pulse;
    logic                   adc_trig;
    logic [N_CH-1:0]        ch_empty;
    logic [N_CH-1:0]        ch_read;
    out_word_t [N_CH-1:0]   ch_data;

    assign o_ccpd_gate = gate_pulse;

    ////////////////////
    // Pulses
    pulse_gen gate_gen (
        .ADC_ENC (ADC_ENC),
        .i_rst_n (i_rst_n),
        .i_start (i_gate_start),
        .i_delay (i_gate_delay),
        .i_width (i_gate_width),
        .o_pulse (gate_pulse)
    );

    pulse_gen inj_gen (
        .ADC_ENC (ADC_ENC),
        .i_rst_n (i_rst_n),
        .i_start (gate_pulse),      // Injection follows the gate edge
        .i_delay (i_inj_delay),
        .i_width (i_inj_width),
        .o_pulse (o_ccpd_injection)
    );

    ////////////////////
    // Trigger and channels
    adc_trigger trig_unit (
        .ADC_ENC     (ADC_ENC),
        .i_rst_n     (i_rst_n),
        .i_src       (i_trig_src),
        .i_gate      (gate_pulse),
        .i_sample    (i_adc_sample[0]),     // Threshold on channel 0 only
        .i_threshold (i_threshold),
        .o_trig      (adc_trig)
    );

    for (genvar i = 0; i < N_CH; i++)
    begin : ch_gen
        adc_channel_rx #(
            .CH_ID (i)
        ) rx (
            .ADC_ENC   (ADC_ENC),
            .i_rst_n   (i_rst_n),
            .i_trig    (adc_trig),
            .i_sample  (i_adc_sample[i]),
            .i_rec_len (i_rec_len),
            .i_read    (ch_read[i]),
            .o_empty   (ch_empty[i]),
            .o_data    (ch_data[i]),
            .o_lost    (o_lost[i])
        );
    end

    rr_arbiter arbiter (
        .ADC_ENC     (ADC_ENC),
        .i_rst_n     (i_rst_n),
        .i_ch_en     (i_ch_en),
        .i_empty     (ch_empty),
        .i_data      (ch_data),
        .o_read      (ch_read),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data),
        .i_out_ready (i_out_ready)
    );

endmodule

// File: src/pulse_gen.sv
////////////////////
// Delay-then-width pulse on a rising edge of i_start
// i_delay and i_width are ADC_ENC cycles, both at least 1
// Start edges seen while busy are dropped
////////////////////

`timescale 1ns/1ps

module pulse_gen (
    input  logic              ADC_ENC,
    input  logic              i_rst_n,
    input  logic              i_start,
    input  sampler_pkg::cnt_t i_delay,
    input  sampler_pkg::cnt_t i_width,
    output logic              o_pulse
);
    import sampler_pkg::*;

    pulse_state_t state;
    cnt_t         cnt;          // Delay first, then width
    logic         start_q;
    logic         start_rise;

    assign start_rise = i_start & ~start_q;

    always_ff @(posedge ADC_ENC)
    begin
        if (!i_rst_n)
        begin
            state   <= IDLE;
            cnt     <= '0;
            start_q <= 1'b0;
            o_pulse <= 1'b0;
        end
        else
        begin
            start_q <= i_start;
            case (state)
                IDLE:
                begin
                    if (start_rise)
                    begin
                        state <= DELAY;
                        cnt   <= i_delay;   // One extra cycle gives D+1 to the first high
                    end
                end
                DELAY:
                begin
                    if (cnt == '0)
                    begin
                        state   <= HIGH;
                        cnt     <= i_width - 1'b1;
                        o_pulse <= 1'b1;
                    end
                    else
                    begin
                        cnt <= cnt - 1'b1;
                    end
                end
                HIGH:
                begin
                    if (cnt == '0)
                    begin
                        state   <= IDLE;
                        o_pulse <= 1'b0;
                    end
                    else
                    begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default:
                begin
                    state   <= IDLE;
                    o_pulse <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: src/rr_arbiter.sv
////////////////////
// Round-robin merge of the channel FIFOs
// One read strobe per cycle at most
// Output held until i_out_ready
////////////////////

`timescale 1ns/1ps

module rr_arbiter (
    input  logic                                        ADC_ENC,
    input  logic                                        i_rst_n,
    input  logic [sampler_pkg::N_CH-1:0]                i_ch_en,
    input  logic [sampler_pkg::N_CH-1:0]                i_empty,
    input  sampler_pkg::out_word_t [sampler_pkg::N_CH-1:0] i_data,
    output logic [sampler_pkg::N_CH-1:0]                o_read,
    output logic                                        o_out_valid,
    output sampler_pkg::out_word_t                      o_out_data,
    input  logic                                        i_out_ready
);
    import sampler_pkg::*;

    logic [N_CH-1:0]    req;
    logic [CH_ID_W-1:0] last_q;
    logic [CH_ID_W-1:0] cand;
    logic [CH_ID_W-1:0] gnt;
    logic               found;
    logic               can_load;
    logic               load;

    assign req      = i_ch_en & ~i_empty;
    assign can_load = ~o_out_valid | i_out_ready;   // Register empty or draining
    assign load     = found & can_load;

    // Descending scan lets the nearest requester after last_q win
    always_comb
    begin
        cand  = last_q;
        gnt   = last_q;
        found = 1'b0;
        for (int off = N_CH; off >= 1; off--)
        begin
            cand = CH_ID_W'((int'(last_q) + off) % N_CH);
            if (req[cand])
            begin
                gnt   = cand;
                found = 1'b1;
            end
        end
    end

    always_comb
    begin
        o_read = '0;
        if (load)
            o_read[gnt] = 1'b1;
    end

    always_ff @(posedge ADC_ENC)
    begin
        if (!i_rst_n)
        begin
            last_q      <= '0;
            o_out_valid <= 1'b0;
        end
        else if (load)
        begin
            last_q      <= gnt;
            o_out_valid <= 1'b1;
        end
        else if (i_out_ready)
        begin
            o_out_valid <= 1'b0;
        end
    end

    always_ff @(posedge ADC_ENC)
    begin
        if (load)
            o_out_data <= i_data[gnt];  // FWFT head word
    end

endmodule

// File: src/sampler_pkg.sv
////////////////////
// Shared widths, types and FSM states for the ADC_ENC domain
// FIFO_DEPTH must be a power of two
// N_CH must fit in CH_ID_W bits
////////////////////

package sampler_pkg;

    localparam int N_CH       = 4;
    localparam int SAMPLE_W   = 14;
    localparam int CH_ID_W    = 2;
    localparam int CNT_W      = 8;
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = FIFO_PTR_W + 1;     // Fill count reaches FIFO_DEPTH
    localparam int WORD_W     = 32;
    localparam int RSVD_W     = WORD_W - 2 - CH_ID_W - SAMPLE_W;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [CNT_W-1:0]    cnt_t;

    // Output stream word, unused bits stay zero
    typedef struct packed {
        logic               first;      // Bit 31, first word of a record
        logic               rsvd_hi;    // Bit 30
        logic [CH_ID_W-1:0] ch_id;      // Bits 29..28
        logic [RSVD_W-1:0]  rsvd_lo;    // Bits 27..14
        sample_t            sample;     // Bits 13..0
    } out_word_t;

    typedef enum logic [1:0] {
        IDLE,
        DELAY,
        HIGH
    } pulse_state_t;

    typedef enum logic {
        WAIT_TRIG,
        RECORD
    } rx_state_t;

    typedef enum logic {
        TRIG_GATE,
        TRIG_THRESH
    } trig_src_t;

endpackage

// File: vlog.f
src/sampler_pkg.sv
src/pulse_gen.sv
src/adc_trigger.sv
src/adc_channel_rx.sv
src/rr_arbiter.sv
src/ccpd_top.sv
bench/ccpd_top_checker.sv
bench/ccpd_top_tb.sv
